// File: flist.f
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/idex_reg.sv
hdl/execute_stage.sv
hdl/wb_mem_ctrl.sv
hdl/cpu_core.sv
sim/tb_clock.sv
sim/tb_cpu.sv

// File: hdl/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
    parameter logic [15:0] reset_pc = 16'h0000
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [15:0] instr_addr,
    input  logic [15:0] instr_data,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [15:0] wb_adr,
    output logic [15:0] wb_dat_o,
    input  logic [15:0] wb_dat_i,
    input  logic        wb_ack,
    output logic        halted
);

    logic [15:0]           pc;
    cpu_isa_pkg::instr_u   if_id_instr;
    logic [15:0]           if_id_pc;
    cpu_pipe_pkg::idex_t   id_idex;
    cpu_pipe_pkg::idex_t   ex_idex;
    cpu_pipe_pkg::exmem_t  ex_exmem;
    cpu_pipe_pkg::exmem_t  mem_exmem;
    cpu_isa_pkg::reg_idx_t rf_raddr1;
    cpu_isa_pkg::reg_idx_t rf_raddr2;
    cpu_isa_pkg::reg_idx_t rf_waddr;
    logic [15:0]           rf_rdata1;
    logic [15:0]           rf_rdata2;
    logic [15:0]           rf_wdata;
    logic                  rf_we;
    logic                  id_uses_rt;
    logic                  hold_front;
    logic                  bubble;
    logic                  flush;
    logic                  branch_taken;
    logic [15:0]           branch_target;
    logic                  mem_busy;

    assign instr_addr = pc;
    assign id_uses_rt = id_idex.ctrl.mem_write
                      || (id_idex.ctrl.reg_write && !id_idex.ctrl.alu_use_imm);

    // PC and IF/ID
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= reset_pc;
            if_id_instr <= cpu_isa_pkg::nop_instr;
        end else if (!mem_busy) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (!hold_front) begin
                pc <= pc + 16'd1;
            end
            if (flush) begin
                if_id_instr <= cpu_isa_pkg::nop_instr;
            end else if (!hold_front) begin
                if_id_instr <= instr_data;
                if_id_pc    <= pc;
            end
        end
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_exmem.mem_read  <= 1'b0;
            mem_exmem.mem_write <= 1'b0;
            mem_exmem.reg_write <= 1'b0;
            mem_exmem.halt      <= 1'b0;
        end else if (!mem_busy) begin
            mem_exmem <= ex_exmem;
        end
    end

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    decode_stage u_decode (
        .instr(if_id_instr), .pc(if_id_pc),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .idex(id_idex)
    );

    hazard_unit u_hazard (
        .id_rs(id_idex.rs), .id_rt(id_idex.rt), .id_uses_rt(id_uses_rt),
        .ex_rd(ex_idex.rd), .ex_mem_read(ex_idex.ctrl.mem_read),
        .branch_taken(branch_taken),
        .hold_front(hold_front), .bubble(bubble), .flush(flush)
    );

    idex_reg u_idex_reg (
        .clk(clk), .rst_n(rst_n), .hold(mem_busy), .bubble(bubble),
        .idex_in(id_idex), .idex_out(ex_idex)
    );

    execute_stage u_execute (
        .idex(ex_idex), .fwd(mem_exmem), .exmem(ex_exmem),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    wb_mem_ctrl u_mem_ctrl (
        .clk(clk), .rst_n(rst_n), .exmem(mem_exmem),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .mem_busy(mem_busy), .halted(halted)
    );

endmodule

`default_nettype wire

// File: hdl/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_alu  = 4'h1,
        op_addi = 4'h2,
        op_ld   = 4'h3,
        op_st   = 4'h4,
        op_beqz = 4'h5,
        op_halt = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        fn_add = 2'b00,
        fn_sub = 2'b01,
        fn_and = 2'b10,
        fn_xor = 2'b11
    } funct_t;

    // Register format, rd = rs op rt
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        logic     pad;
        funct_t   funct;
    } instr_r_t;

    // Immediate format for ADDI, LD, ST and BEQZ
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;          // Store data register for ST
        reg_idx_t   rs;
        logic [5:0] imm;         // Two's complement
    } instr_i_t;

    typedef union packed {
        instr_r_t r_fmt;
        instr_i_t i_fmt;
    } instr_u;

    localparam instr_u nop_instr = instr_u'({op_nop, 12'h000});

endpackage

`default_nettype wire

// File: hdl/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

    typedef struct packed {
        logic                alu_use_imm;
        logic                mem_read;
        logic                mem_write;
        logic                reg_write;
        logic                branch;
        logic                halt;
        cpu_isa_pkg::funct_t funct;
    } ctrl_t;

    typedef struct packed {
        logic [15:0]           pc;
        logic [15:0]           read1;
        logic [15:0]           read2;
        logic [15:0]           imm;
        cpu_isa_pkg::reg_idx_t rs;
        cpu_isa_pkg::reg_idx_t rt;     // Second source, rd field for ST
        cpu_isa_pkg::reg_idx_t rd;
        ctrl_t                 ctrl;
    } idex_t;

    typedef struct packed {
        logic [15:0]           result;   // ALU value or data address
        logic [15:0]           store_data;
        cpu_isa_pkg::reg_idx_t rd;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic                  halt;
    } exmem_t;

endpackage

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  cpu_isa_pkg::instr_u   instr,
    input  logic [15:0]           pc,
    output cpu_isa_pkg::reg_idx_t rf_raddr1,
    output cpu_isa_pkg::reg_idx_t rf_raddr2,
    input  logic [15:0]           rf_rdata1,
    input  logic [15:0]           rf_rdata2,
    output cpu_pipe_pkg::idex_t   idex
);

    cpu_pipe_pkg::ctrl_t dec_ctrl;
    logic                is_store;

    assign is_store  = (instr.i_fmt.opcode == cpu_isa_pkg::op_st);
    assign rf_raddr1 = instr.r_fmt.rs;
    assign rf_raddr2 = is_store ? instr.i_fmt.rd : instr.r_fmt.rt;

    always_comb begin
        dec_ctrl = '0;
        case (instr.r_fmt.opcode)
            cpu_isa_pkg::op_alu: begin
                dec_ctrl.reg_write = 1'b1;
                dec_ctrl.funct     = instr.r_fmt.funct;
            end
            cpu_isa_pkg::op_addi: begin
                dec_ctrl.alu_use_imm = 1'b1;
                dec_ctrl.reg_write   = 1'b1;
            end
            cpu_isa_pkg::op_ld: begin
                dec_ctrl.alu_use_imm = 1'b1;
                dec_ctrl.mem_read    = 1'b1;
                dec_ctrl.reg_write   = 1'b1;
            end
            cpu_isa_pkg::op_st: begin
                dec_ctrl.alu_use_imm = 1'b1;
                dec_ctrl.mem_write   = 1'b1;
            end
            cpu_isa_pkg::op_beqz: dec_ctrl.branch = 1'b1;
            cpu_isa_pkg::op_halt: dec_ctrl.halt   = 1'b1;
            default: ;                                   // NOP and unused codes
        endcase
    end

    always_comb begin
        idex.pc    = pc;
        idex.read1 = rf_rdata1;
        idex.read2 = rf_rdata2;
        idex.imm   = {{10{instr.i_fmt.imm[5]}}, instr.i_fmt.imm};
        idex.rs    = rf_raddr1;
        idex.rt    = rf_raddr2;
        idex.rd    = instr.r_fmt.rd;
        idex.ctrl  = dec_ctrl;
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  cpu_pipe_pkg::idex_t  idex,
    input  cpu_pipe_pkg::exmem_t fwd,
    output cpu_pipe_pkg::exmem_t exmem,
    output logic                 branch_taken,
    output logic [15:0]          branch_target
);

    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [15:0] alu_b;
    logic [15:0] alu_out;

    // Bypass from the instruction one stage ahead
    assign op_a  = (fwd.reg_write && fwd.rd == idex.rs) ? fwd.result : idex.read1;
    assign op_b  = (fwd.reg_write && fwd.rd == idex.rt) ? fwd.result : idex.read2;
    assign alu_b = idex.ctrl.alu_use_imm ? idex.imm : op_b;

    always_comb begin
        case (idex.ctrl.funct)
            cpu_isa_pkg::fn_add: alu_out = op_a + alu_b;   // Also ADDI and addresses
            cpu_isa_pkg::fn_sub: alu_out = op_a - alu_b;
            cpu_isa_pkg::fn_and: alu_out = op_a & alu_b;
            cpu_isa_pkg::fn_xor: alu_out = op_a ^ alu_b;
            default:             alu_out = op_a + alu_b;
        endcase
    end

    always_comb begin
        exmem.result     = alu_out;
        exmem.store_data = op_b;
        exmem.rd         = idex.rd;
        exmem.mem_read   = idex.ctrl.mem_read;
        exmem.mem_write  = idex.ctrl.mem_write;
        exmem.reg_write  = idex.ctrl.reg_write;
        exmem.halt       = idex.ctrl.halt;
    end

    assign branch_taken  = idex.ctrl.branch && (op_a == 16'h0000);
    assign branch_target = idex.pc + 16'd1 + idex.imm;

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  cpu_isa_pkg::reg_idx_t id_rs,
    input  cpu_isa_pkg::reg_idx_t id_rt,
    input  logic                  id_uses_rt,
    input  cpu_isa_pkg::reg_idx_t ex_rd,
    input  logic                  ex_mem_read,
    input  logic                  branch_taken,
    output logic                  hold_front,
    output logic                  bubble,
    output logic                  flush
);

    logic load_use;

    // Load result is not ready until after the memory stage
    assign load_use = ex_mem_read && ((ex_rd == id_rs) || (id_uses_rt && ex_rd == id_rt));

    assign flush      = branch_taken;
    assign hold_front = load_use && !branch_taken;   // Branch wins
    assign bubble     = load_use || branch_taken;

endmodule

`default_nettype wire

// File: hdl/idex_reg.sv
`timescale 1ns/100ps
`default_nettype none

module idex_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hold,
    input  logic                bubble,
    input  cpu_pipe_pkg::idex_t idex_in,
    output cpu_pipe_pkg::idex_t idex_out
);

    cpu_pipe_pkg::idex_t idex_next;

    // Payload is kept, only the side effects are zeroed
    always_comb begin
        idex_next = idex_in;
        if (bubble) begin
            idex_next.ctrl.mem_read  = 1'b0;
            idex_next.ctrl.mem_write = 1'b0;
            idex_next.ctrl.reg_write = 1'b0;
            idex_next.ctrl.branch    = 1'b0;
            idex_next.ctrl.halt      = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idex_out.ctrl <= '0;
        end else if (!hold) begin
            idex_out <= idex_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_isa_pkg::reg_idx_t raddr1,
    input  cpu_isa_pkg::reg_idx_t raddr2,
    output logic [15:0]           rdata1,
    output logic [15:0]           rdata2,
    input  logic                  we,
    input  cpu_isa_pkg::reg_idx_t waddr,
    input  logic [15:0]           wdata
);

    logic [15:0] regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through covers the writeback to decode distance
    assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/wb_mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_pipe_pkg::exmem_t  exmem,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [15:0]           wb_adr,
    output logic [15:0]           wb_dat_o,
    input  logic [15:0]           wb_dat_i,
    input  logic                  wb_ack,
    output logic                  rf_we,
    output cpu_isa_pkg::reg_idx_t rf_waddr,
    output logic [15:0]           rf_wdata,
    output logic                  mem_busy,
    output logic                  halted
);

    typedef enum logic [1:0] {
        s_idle,
        s_access,
        s_done,
        s_halt
    } state_t;

    state_t state;
    state_t state_next;
    logic   mem_op;

    assign mem_op = exmem.mem_read || exmem.mem_write;

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (exmem.halt) state_next = s_halt;
                else if (mem_op) state_next = s_access;
            end
            s_access: if (wb_ack) state_next = s_done;
            s_done:   state_next = s_idle;   // Bus released, pipeline moves
            default:  state_next = s_halt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    assign wb_cyc   = (state == s_access);
    assign wb_stb   = (state == s_access);
    assign wb_we    = (state == s_access) && exmem.mem_write;
    assign wb_adr   = exmem.result;
    assign wb_dat_o = exmem.store_data;

    // Loads write on ack, everything else while passing through idle
    assign rf_we    = (state == s_access) ? (exmem.mem_read && wb_ack)
                    : (state == s_idle && exmem.reg_write && !mem_op && !exmem.halt);
    assign rf_waddr = exmem.rd;
    assign rf_wdata = (state == s_access) ? wb_dat_i : exmem.result;

    assign mem_busy = (state == s_idle && (mem_op || exmem.halt))
                    || state == s_access || state == s_halt;
    assign halted   = (state == s_halt);

    a_adr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> $stable(wb_adr)
    ) else $error("wb_mem_ctrl: address moved during a bus cycle");

    a_ctrl_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> ($stable(wb_we) && $stable(wb_dat_o))
    ) else $error("wb_mem_ctrl: write enable or data moved during a bus cycle");

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cpu -f flist.f

./obj_dir/Vtb_cpu

// File: sim/cpu_stimulus.txt
// @00 program length, expected store count, final word count, random wait enable
// @10 program words, @40 expected stores {addr, data}, @80 final memory {addr, data}
@00
0000001A
00000008
0000000C
00000001
@10
00002205 // ADDI r1, r0, 5
0000243D // ADDI r2, r0, -3
00001650 // ADD  r3, r1, r2
000018C9 // SUB  r4, r3, r1
00001B1B // XOR  r5, r4, r3
00001D4A // AND  r6, r5, r1
00004610 // ST   r3, 16(r0)
00004811 // ST   r4, 17(r0)
00004A12 // ST   r5, 18(r0)
00004C13 // ST   r6, 19(r0)
00003E04 // LD   r7, 4(r0)
00001FC8 // ADD  r7, r7, r1  load-use
00004E14 // ST   r7, 20(r0)
00003410 // LD   r2, 16(r0)
00004415 // ST   r2, 21(r0)  load-use on store data
00005002 // BEQZ r0, +2      taken
00004216 // ST   r1, 22(r0)  skipped
00004217 // ST   r1, 23(r0)  skipped
00005042 // BEQZ r1, +2      not taken
00004218 // ST   r1, 24(r0)
00001849 // SUB  r4, r1, r1
00005102 // BEQZ r4, +2      taken through forwarding
00004219 // ST   r1, 25(r0)  skipped
0000421A // ST   r1, 26(r0)  skipped
0000481B // ST   r4, 27(r0)
0000F000 // HALT
@40
00100002
0011FFFD
0012FFFF
00130005
00140500
00150002
00180005
001B0000
@80
00100002
0011FFFD
0012FFFF
00130005
00140500
00150002
001616E9
001717E8
00180005
001919E6
001A1AE5
001B0000

// File: sim/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

    localparam int prog_base     = 'h10;
    localparam int store_base    = 'h40;
    localparam int final_base    = 'h80;
    localparam int reset_timeout = 20;
    localparam int halt_timeout  = 4000;
    localparam int drain_cycles  = 20;

    logic        clk;
    logic        rst_n;
    logic [15:0] instr_addr;
    logic [15:0] instr_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [15:0] wb_dat_o;
    logic [15:0] wb_dat_i;
    logic        wb_ack;
    logic        halted;

    logic [31:0] stim [256];
    logic [15:0] rom  [256];
    logic [15:0] dmem [256];
    logic [31:0] lfsr;
    logic        random_waits;
    int          n_stores;
    int          n_final;
    int          store_count;

    tb_clock #(
        .half_period(10),
        .reset_cycles(4)
    ) u_clock (
        .clk(clk),
        .rst_n(rst_n)
    );

    cpu_core #(
        .reset_pc(16'h0000)
    ) dut (
        .clk(clk), .rst_n(rst_n),
        .instr_addr(instr_addr), .instr_data(instr_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .halted(halted)
    );

    assign instr_data = rom[instr_addr[7:0]];   // Same-cycle fetch

    task automatic end_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_wait_count(output int count);
        logic [1:0] bits;
        lfsr    = lfsr_step(lfsr);
        bits[0] = lfsr[0];
        lfsr    = lfsr_step(lfsr);
        bits[1] = lfsr[0];
        count   = {30'd0, bits};
    endtask

    task automatic serve_access();
        if (wb_adr > 16'h00ff) begin
            $display("Bus address %h lies outside the data memory", wb_adr);
            end_with_failure();
        end
        if (wb_we) begin
            if (store_count >= n_stores) begin
                $display("Store of %h to %h came after the last expected store",
                         wb_dat_o, wb_adr);
                end_with_failure();
            end
            compare($sformatf("store %0d", store_count),
                    stim[8'(store_base + store_count)], {wb_adr, wb_dat_o});
            dmem[wb_adr[7:0]] = wb_dat_o;
            store_count++;
        end else begin
            wb_dat_i <= dmem[wb_adr[7:0]];
        end
    endtask

    // Wishbone slave, 0 to 3 wait states per cycle
    initial begin
        int   waits_left;
        logic in_cycle;
        wb_ack     = 1'b0;
        wb_dat_i   = 16'h0000;
        lfsr       = 32'hf7a6_0a14;
        waits_left = 0;
        in_cycle   = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n || wb_ack) begin
                wb_ack  <= 1'b0;                  // Master drops stb after ack
                in_cycle = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!in_cycle) begin
                    in_cycle   = 1'b1;
                    waits_left = 0;
                    if (random_waits) draw_wait_count(waits_left);
                end
                if (waits_left == 0) begin
                    serve_access();
                    wb_ack <= 1'b1;
                end else begin
                    waits_left--;
                end
            end
        end
    end

    initial begin
        int          n_prog;
        int          cycles;
        logic [31:0] entry;
        $readmemh("sim/cpu_stimulus.txt", stim);
        n_prog       = stim[0];
        n_stores     = stim[1];
        n_final      = stim[2];
        random_waits = stim[3][0];
        store_count  = 0;
        for (int i = 0; i < 256; i++) begin
            rom[8'(i)]  = (i < n_prog) ? stim[8'(prog_base + i)][15:0] : 16'h0000;
            dmem[8'(i)] = {i[7:0], ~i[7:0]};      // Low byte inverted
        end

        cycles = 0;
        while (!rst_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > reset_timeout) begin
                $display("Timeout: reset was never released");
                end_with_failure();
            end
        end

        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            cycles++;
            if (cycles > halt_timeout) begin
                $display("Timeout: halted did not rise within %0d cycles", halt_timeout);
                end_with_failure();
            end
        end

        for (int c = 0; c < drain_cycles; c++) begin
            @(posedge clk);
            compare("halted stays high", 32'd1, {31'd0, halted});
            if (wb_cyc || wb_stb) begin
                $display("A bus cycle started after halted rose");
                end_with_failure();
            end
        end

        compare("store count", n_stores, store_count);
        for (int k = 0; k < n_final; k++) begin
            entry = stim[8'(final_base + k)];
            compare($sformatf("memory word %h", entry[31:16]), {16'h0000, entry[15:0]},
                    {16'h0000, dmem[entry[23:16]]});
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
